// ==== Makefile ====
# Verilator build for the integer execution unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= iu_tb
FILELIST  ?= iu_exec.f
PASS_MSG  := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Output goes to the terminal and is searched for the pass message
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== dv/iu_props.sv ====
// Checker bound into iu_top
// Reset values, stall qualification and a known write-back valid

`timescale 1ns/1ps
`default_nettype none

module iu_props (
  input logic forever_cpuclk,
  input logic arst_n,
  input logic inst_vld,
  input logic stall,
  input logic wb_vld
);

  // First edge out of reset
  assert property (@(posedge forever_cpuclk) $rose(arst_n) |-> !wb_vld && !stall)
    else $error("wb_vld or stall high after reset");

  assert property (@(posedge forever_cpuclk) disable iff (!arst_n) stall |-> inst_vld)
    else $error("stall high with no instruction offered");

  assert property (@(posedge forever_cpuclk) disable iff (!arst_n) !$isunknown(wb_vld))
    else $error("wb_vld unknown");

endmodule

bind iu_top iu_props i_props (
  .forever_cpuclk (forever_cpuclk),
  .arst_n         (arst_n),
  .inst_vld       (inst_vld),
  .stall          (stall),
  .wb_vld         (wb_vld)
);

`default_nettype wire

// ==== dv/iu_tb.sv ====
// Testbench for iu_top at XLEN 32
// Outputs are checked at the falling edge, inputs change there too
// Pipelined results are matched by due cycle, anything else must be the divide

`timescale 1ns/1ps
`default_nettype none

module iu_tb;

  localparam int XLEN       = 32;
  localparam int N_RAND     = 40;
  localparam int N_DIV      = 14;
  localparam int N_INST     = 1 + 3 * N_RAND + N_DIV + 2 + 8;
  localparam int MAX_CYCLES = 40 * N_INST + 5;

  logic            clk;
  logic            arst_n;
  logic            flush;
  logic            inst_vld;
  iu_pkg::func_t   func;
  logic [XLEN-1:0] src0;
  logic [XLEN-1:0] src1;
  iu_pkg::preg_t   dst_preg;
  logic            stall;
  logic            wb_vld;
  iu_pkg::preg_t   wb_preg;
  logic [XLEN-1:0] wb_data;

  // Reference model state
  iu_pkg::preg_t   exp_preg[$];
  logic [XLEN-1:0] exp_data[$];
  int              exp_due[$];
  logic            div_pend;
  iu_pkg::preg_t   div_preg;
  logic [XLEN-1:0] div_data;

  int              cyc;
  int              errs;
  logic [31:0]     lfsr;
  logic            stall_seen;
  iu_pkg::preg_t   next_tag;

  iu_pkg::func_t alu_funcs[10] = '{iu_pkg::FUNC_ADD, iu_pkg::FUNC_SUB, iu_pkg::FUNC_AND,
    iu_pkg::FUNC_OR, iu_pkg::FUNC_XOR, iu_pkg::FUNC_SLL, iu_pkg::FUNC_SRL,
    iu_pkg::FUNC_SRA, iu_pkg::FUNC_SLT, iu_pkg::FUNC_SLTU};
  iu_pkg::func_t mul_funcs[4] = '{iu_pkg::FUNC_MUL, iu_pkg::FUNC_MULH,
    iu_pkg::FUNC_MULHSU, iu_pkg::FUNC_MULHU};
  iu_pkg::func_t div_funcs[4] = '{iu_pkg::FUNC_DIV, iu_pkg::FUNC_DIVU,
    iu_pkg::FUNC_REM, iu_pkg::FUNC_REMU};

  iu_top #(.XLEN(XLEN)) i_dut (
    .forever_cpuclk (clk),
    .arst_n         (arst_n),
    .flush          (flush),
    .inst_vld       (inst_vld),
    .func           (func),
    .src0           (src0),
    .src1           (src1),
    .dst_preg       (dst_preg),
    .stall          (stall),
    .wb_vld         (wb_vld),
    .wb_preg        (wb_preg),
    .wb_data        (wb_data)
  );

  always #10 clk = ~clk;

  task automatic stop_run(input string why);
    errs++;
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic value_fail(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
    stop_run("wrong write-back value");
  endtask

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return val;
  endfunction

  function automatic logic [XLEN-1:0] ref_result(input iu_pkg::func_t f,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    logic [63:0]            prod;
    sa = a;
    sb = b;
    prod = '0;
    case (f)
      iu_pkg::FUNC_ADD:    return a + b;
      iu_pkg::FUNC_SUB:    return a - b;
      iu_pkg::FUNC_AND:    return a & b;
      iu_pkg::FUNC_OR:     return a | b;
      iu_pkg::FUNC_XOR:    return a ^ b;
      iu_pkg::FUNC_SLL:    return a << b[4:0];
      iu_pkg::FUNC_SRL:    return a >> b[4:0];
      iu_pkg::FUNC_SRA:    return sa >>> b[4:0];
      iu_pkg::FUNC_SLT:    return (sa < sb) ? 1 : 0;
      iu_pkg::FUNC_SLTU:   return (a < b) ? 1 : 0;
      iu_pkg::FUNC_MUL:    return a * b;
      iu_pkg::FUNC_MULH:   prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
      iu_pkg::FUNC_MULHSU: prod = {{32{a[31]}}, a} * {32'h0, b};
      iu_pkg::FUNC_MULHU:  prod = {32'h0, a} * {32'h0, b};
      iu_pkg::FUNC_DIV, iu_pkg::FUNC_REM: begin
        if (b == 0) begin
          return (f == iu_pkg::FUNC_DIV) ? '1 : a;
        end
        if (a == 32'h8000_0000 && b == '1) begin
          return (f == iu_pkg::FUNC_DIV) ? a : '0;
        end
        return (f == iu_pkg::FUNC_DIV) ? sa / sb : sa % sb;
      end
      iu_pkg::FUNC_DIVU:   return (b == 0) ? '1 : a / b;
      iu_pkg::FUNC_REMU:   return (b == 0) ? a : a % b;
      default:             return '0;
    endcase
    return prod[63:32];
  endfunction

  // Offer one instruction, holding it while stalled
  task automatic issue(input iu_pkg::func_t f, input logic [XLEN-1:0] a,
                       input logic [XLEN-1:0] b);
    logic is_div;
    logic is_pipe;
    @(negedge clk);
    inst_vld = 1'b1;
    func     = f;
    src0     = a;
    src1     = b;
    dst_preg = next_tag;
    #5;
    while (stall) begin
      stall_seen = 1'b1;
      @(negedge clk);
      #5;
    end
    is_div  = f inside {div_funcs};
    is_pipe = f inside {alu_funcs, mul_funcs};
    if (is_div) begin
      assert (!div_pend) else stop_run("second divide accepted before the first was granted");
      div_pend = 1'b1;
      div_preg = next_tag;
      div_data = ref_result(f, a, b);
    end else if (is_pipe) begin
      exp_preg.push_back(next_tag);
      exp_data.push_back(ref_result(f, a, b));
      exp_due.push_back(cyc + 2);
    end
    next_tag = next_tag + 1'b1;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      inst_vld = 1'b0;
      flush    = 1'b0;
    end
  endtask

  // Model state is read clear of the checker's falling edge
  task automatic drain();
    idle(1);
    #5;
    while (exp_due.size() > 0 || div_pend) begin
      @(negedge clk);
      #5;
    end
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      stop_run("timeout waiting for the DUT");
    end
  end

  // Write-back checker
  always @(negedge clk) begin
    if (arst_n) begin
      if (exp_due.size() > 0 && exp_due[0] == cyc) begin
        assert (wb_vld) else stop_run("pipelined result missing at its write-back cycle");
        assert (wb_preg == exp_preg[0]) else value_fail("wb_preg", wb_preg, exp_preg[0]);
        assert (wb_data == exp_data[0]) else value_fail("wb_data", wb_data, exp_data[0]);
        void'(exp_preg.pop_front());
        void'(exp_data.pop_front());
        void'(exp_due.pop_front());
      end else if (wb_vld) begin
        assert (div_pend) else stop_run("write-back with no result expected");
        assert (wb_preg == div_preg) else value_fail("wb_preg", wb_preg, div_preg);
        assert (wb_data == div_data) else value_fail("wb_data", wb_data, div_data);
        div_pend = 1'b0;
      end
    end
  end

  initial begin
    logic [XLEN-1:0] da[N_DIV];
    logic [XLEN-1:0] db[N_DIV];
    clk        = 1'b0;
    arst_n     = 1'b0;
    flush      = 1'b0;
    inst_vld   = 1'b0;
    func       = iu_pkg::FUNC_ADD;
    src0       = '0;
    src1       = '0;
    dst_preg   = '0;
    cyc        = 0;
    errs       = 0;
    lfsr       = 32'd89854;
    stall_seen = 1'b0;
    next_tag   = '0;
    div_pend   = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Illegal code must produce no write-back
    issue(iu_pkg::func_t'(5'h0c), 32'h1234, 32'h5678);
    idle(6);

    for (int i = 0; i < N_RAND; i++) begin
      issue(alu_funcs[rand_bits(4) % 10], rand_bits(32), rand_bits(32));
    end
    drain();
    for (int i = 0; i < N_RAND; i++) begin
      if (rand_bits(1)) begin
        issue(mul_funcs[rand_bits(2)], rand_bits(32), rand_bits(32));
      end else begin
        issue(alu_funcs[rand_bits(4) % 10], rand_bits(32), rand_bits(32));
      end
    end
    drain();

    // Zero divisor on all four codes, negative dividend for the signed ones
    for (int i = 0; i < 4; i++) begin
      da[i] = (i % 2 == 0) ? 32'hffff_fff3 : 32'd77;
      db[i] = '0;
    end
    // Most negative by minus one on all four codes
    for (int i = 4; i < 8; i++) begin
      da[i] = 32'h8000_0000;
      db[i] = 32'hffff_ffff;
    end
    for (int i = 8; i < N_DIV; i++) begin
      da[i] = rand_bits(32);
      db[i] = rand_bits(32) >> rand_bits(5);
    end
    for (int i = 0; i < N_DIV; i++) begin
      issue(div_funcs[i % 4], da[i], db[i]);
      drain();
    end

    // Second divide stalls while ALU ops keep the port busy
    issue(iu_pkg::FUNC_DIV, rand_bits(32), rand_bits(16));
    for (int i = 0; i < N_RAND; i++) begin
      issue(alu_funcs[rand_bits(4) % 10], rand_bits(32), rand_bits(32));
    end
    issue(iu_pkg::FUNC_REMU, rand_bits(32), rand_bits(8));
    assert (stall_seen) else stop_run("stall never raised for a second divide");
    drain();

    // Flush with a divide and pipelined work in flight
    issue(iu_pkg::FUNC_DIVU, rand_bits(32), rand_bits(12));
    issue(iu_pkg::FUNC_ADD, rand_bits(32), rand_bits(32));
    issue(iu_pkg::FUNC_MULH, rand_bits(32), rand_bits(32));
    @(negedge clk);
    flush    = 1'b1;
    inst_vld = 1'b1;
    func     = iu_pkg::FUNC_XOR;
    #5;
    exp_preg.delete();
    exp_data.delete();
    exp_due.delete();
    div_pend = 1'b0;
    idle(XLEN + 8);
    issue(iu_pkg::FUNC_SUB, rand_bits(32), rand_bits(32));
    issue(iu_pkg::FUNC_MULHU, rand_bits(32), rand_bits(32));
    drain();
    idle(4);

    if (errs == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      stop_run("errors recorded during the run");
    end
  end

endmodule

`default_nettype wire

// ==== iu_exec.f ====
source/iu_pkg.sv
source/iu_decode.sv
source/iu_alu.sv
source/iu_mul.sv
source/iu_div.sv
source/iu_wb_ctrl.sv
source/iu_top.sv
dv/iu_props.sv
dv/iu_tb.sv

// ==== source/iu_alu.sv ====
// Combinational integer ALU
// Shift amount uses the low log2(XLEN) bits of src1

`timescale 1ns/1ps
`default_nettype none

module iu_alu #(
  parameter int XLEN = 32
) (
  input  iu_pkg::alu_op_t  alu_op,
  input  logic [XLEN-1:0]  src0,
  input  logic [XLEN-1:0]  src1,
  output logic [XLEN-1:0]  rslt
);

  localparam int SHW = $clog2(XLEN);

  logic [SHW-1:0] shamt;
  logic           lt_s;
  logic           lt_u;

  assign shamt = src1[SHW-1:0];
  assign lt_s  = $signed(src0) < $signed(src1);
  assign lt_u  = src0 < src1;

  always_comb begin
    case (alu_op)
      iu_pkg::ALU_ADD:  rslt = src0 + src1;
      iu_pkg::ALU_SUB:  rslt = src0 - src1;
      iu_pkg::ALU_AND:  rslt = src0 & src1;
      iu_pkg::ALU_OR:   rslt = src0 | src1;
      iu_pkg::ALU_XOR:  rslt = src0 ^ src1;
      iu_pkg::ALU_SLL:  rslt = src0 << shamt;
      iu_pkg::ALU_SRL:  rslt = src0 >> shamt;
      iu_pkg::ALU_SRA:  rslt = $unsigned($signed(src0) >>> shamt);
      // Comparisons return 0 or 1
      iu_pkg::ALU_SLT:  rslt = {{(XLEN-1){1'b0}}, lt_s};
      iu_pkg::ALU_SLTU: rslt = {{(XLEN-1){1'b0}}, lt_u};
      default:          rslt = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/iu_decode.sv ====
// Function code decode into unit selects and operation controls
// Selects are gated by inst_vld only; stall and flush are handled in the units
// Illegal codes raise no select

`timescale 1ns/1ps
`default_nettype none

module iu_decode (
  input  logic            inst_vld,
  input  iu_pkg::func_t   func,
  output logic            alu_sel,
  output logic            mul_sel,
  output logic            div_sel,
  output iu_pkg::alu_op_t alu_op,
  output logic            mul_high,
  output logic            mul_src0_signed,
  output logic            mul_src1_signed,
  output logic            div_signed,
  output logic            div_rem
);

  logic is_alu;
  logic is_mul;
  logic is_div;

  assign is_alu = func inside {iu_pkg::FUNC_ADD, iu_pkg::FUNC_SUB, iu_pkg::FUNC_AND,
                               iu_pkg::FUNC_OR, iu_pkg::FUNC_XOR, iu_pkg::FUNC_SLL,
                               iu_pkg::FUNC_SRL, iu_pkg::FUNC_SRA, iu_pkg::FUNC_SLT,
                               iu_pkg::FUNC_SLTU};
  assign is_mul = func inside {iu_pkg::FUNC_MUL, iu_pkg::FUNC_MULH,
                               iu_pkg::FUNC_MULHSU, iu_pkg::FUNC_MULHU};
  assign is_div = func inside {iu_pkg::FUNC_DIV, iu_pkg::FUNC_DIVU,
                               iu_pkg::FUNC_REM, iu_pkg::FUNC_REMU};

  // At most one select per instruction
  assign alu_sel = inst_vld & is_alu;
  assign mul_sel = inst_vld & is_mul;
  assign div_sel = inst_vld & is_div;

  assign mul_high        = func != iu_pkg::FUNC_MUL;
  assign mul_src0_signed = func inside {iu_pkg::FUNC_MULH, iu_pkg::FUNC_MULHSU};
  assign mul_src1_signed = func == iu_pkg::FUNC_MULH;

  assign div_signed = func inside {iu_pkg::FUNC_DIV, iu_pkg::FUNC_REM};
  assign div_rem    = func inside {iu_pkg::FUNC_REM, iu_pkg::FUNC_REMU};

  always_comb begin
    case (func)
      iu_pkg::FUNC_SUB:  alu_op = iu_pkg::ALU_SUB;
      iu_pkg::FUNC_AND:  alu_op = iu_pkg::ALU_AND;
      iu_pkg::FUNC_OR:   alu_op = iu_pkg::ALU_OR;
      iu_pkg::FUNC_XOR:  alu_op = iu_pkg::ALU_XOR;
      iu_pkg::FUNC_SLL:  alu_op = iu_pkg::ALU_SLL;
      iu_pkg::FUNC_SRL:  alu_op = iu_pkg::ALU_SRL;
      iu_pkg::FUNC_SRA:  alu_op = iu_pkg::ALU_SRA;
      iu_pkg::FUNC_SLT:  alu_op = iu_pkg::ALU_SLT;
      iu_pkg::FUNC_SLTU: alu_op = iu_pkg::ALU_SLTU;
      default:           alu_op = iu_pkg::ALU_ADD;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/iu_div.sv ====
// Radix-2 restoring divider, one quotient bit per cycle
// Busy from the accepting edge until the held result is granted
// Divide by zero and signed overflow follow the RISC-V results
// A divide offered while busy sees stall and must be held by the issuer

`timescale 1ns/1ps
`default_nettype none

module iu_div #(
  parameter int XLEN = 32
) (
  input  logic            forever_cpuclk,
  input  logic            arst_n,
  input  logic            flush,
  input  logic            div_sel,
  input  logic            div_signed,
  input  logic            div_rem,
  input  logic [XLEN-1:0] src0,
  input  logic [XLEN-1:0] src1,
  input  iu_pkg::preg_t   dst_preg,
  input  logic            div_grant,
  output logic            stall,
  output logic            done,
  output logic [XLEN-1:0] rslt,
  output iu_pkg::preg_t   preg
);

  localparam int CW = $clog2(XLEN);

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_ITER,
    DIV_HOLD
  } div_state_t;

  div_state_t      state;
  logic [CW-1:0]   cnt;
  logic            start;
  logic            neg0;
  logic            neg1;
  logic [XLEN-1:0] mag0;
  logic [XLEN-1:0] mag1;
  logic [XLEN-1:0] quo;
  logic [XLEN-1:0] rem;
  logic [XLEN-1:0] dvsr;
  logic [XLEN:0]   shifted;
  logic            ge;
  logic            q_neg;
  logic            r_neg;
  logic            rem_sel;

  assign start = (state == DIV_IDLE) & div_sel & ~flush;

  assign neg0 = div_signed & src0[XLEN-1];
  assign neg1 = div_signed & src1[XLEN-1];
  assign mag0 = neg0 ? -src0 : src0;
  assign mag1 = neg1 ? -src1 : src1;

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= DIV_IDLE;
      cnt   <= '0;
    end else if (flush) begin
      state <= DIV_IDLE;
    end else begin
      case (state)
        DIV_IDLE: begin
          if (div_sel) begin
            state <= DIV_ITER;
            cnt   <= '0;
          end
        end
        DIV_ITER: begin
          cnt <= cnt + 1'b1;
          if (cnt == CW'(XLEN - 1)) begin
            state <= DIV_HOLD;
          end
        end
        DIV_HOLD: begin
          if (div_grant) begin
            state <= DIV_IDLE;
          end
        end
        default: state <= DIV_IDLE;
      endcase
    end
  end

  // Partial remainder shifted left with the next dividend bit
  assign shifted = {rem, quo[XLEN-1]};
  assign ge      = shifted >= {1'b0, dvsr};

  always_ff @(posedge forever_cpuclk) begin
    if (start) begin
      quo     <= mag0;
      rem     <= '0;
      dvsr    <= mag1;
      // Zero divisor leaves an all-ones quotient unsigned
      q_neg   <= (neg0 ^ neg1) & (|src1);
      r_neg   <= neg0;
      rem_sel <= div_rem;
      preg    <= dst_preg;
    end else if (state == DIV_ITER) begin
      rem <= ge ? shifted[XLEN-1:0] - dvsr : shifted[XLEN-1:0];
      quo <= {quo[XLEN-2:0], ge};
    end
  end

  // Overflow falls out of the magnitude path as 2^(XLEN-1) negated is the dividend
  assign rslt = rem_sel ? (r_neg ? -rem : rem) : (q_neg ? -quo : quo);

  assign stall = div_sel & (state != DIV_IDLE);
  assign done  = state == DIV_HOLD;

endmodule

`default_nettype wire

// ==== source/iu_mul.sv ====
// Two-stage multiplier
// Partial products register at the accepting edge, the summed result is
// captured by the write-back registers at the next edge
// XLEN must be even

`timescale 1ns/1ps
`default_nettype none

module iu_mul #(
  parameter int XLEN = 32
) (
  input  logic            forever_cpuclk,
  input  logic            arst_n,
  input  logic            flush,
  input  logic            mul_sel,
  input  logic            mul_high,
  input  logic            mul_src0_signed,
  input  logic            mul_src1_signed,
  input  logic [XLEN-1:0] src0,
  input  logic [XLEN-1:0] src1,
  output logic [XLEN-1:0] rslt
);

  localparam int HALF = XLEN / 2;
  localparam int PW   = 2 * XLEN + 2;

  logic signed [XLEN:0]   op0;
  logic signed [HALF:0]   op1_lo;
  logic signed [HALF:0]   op1_hi;
  logic signed [PW-1:0]   pp_lo;
  logic signed [PW-1:0]   pp_hi;
  logic signed [PW-1:0]   prod;
  logic                   high_q;
  logic                   vld_q;

  // Extend by one bit so mixed signedness becomes a signed multiply
  assign op0    = {mul_src0_signed & src0[XLEN-1], src0};
  assign op1_lo = {1'b0, src1[HALF-1:0]};
  assign op1_hi = {mul_src1_signed & src1[XLEN-1], src1[XLEN-1:HALF]};

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= mul_sel & ~flush;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (mul_sel) begin
      pp_lo  <= op0 * op1_lo;
      pp_hi  <= op0 * op1_hi;
      high_q <= mul_high;
    end
  end

  // Second stage
  assign prod = pp_lo + (pp_hi <<< HALF);

  // Idle output held at zero
  assign rslt = !vld_q ? '0 :
                high_q ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];

endmodule

`default_nettype wire

// ==== source/iu_pkg.sv ====
// Shared types for the integer execution unit
// Function codes outside func_t are illegal and produce no write-back

`default_nettype none

package iu_pkg;

  // Instruction function codes
  typedef enum logic [4:0] {
    FUNC_ADD    = 5'h00,
    FUNC_SUB    = 5'h01,
    FUNC_AND    = 5'h02,
    FUNC_OR     = 5'h03,
    FUNC_XOR    = 5'h04,
    FUNC_SLL    = 5'h05,
    FUNC_SRL    = 5'h06,
    FUNC_SRA    = 5'h07,
    FUNC_SLT    = 5'h08,
    FUNC_SLTU   = 5'h09,
    FUNC_MUL    = 5'h10,
    FUNC_MULH   = 5'h11,
    FUNC_MULHSU = 5'h12,
    FUNC_MULHU  = 5'h13,
    FUNC_DIV    = 5'h18,
    FUNC_DIVU   = 5'h19,
    FUNC_REM    = 5'h1a,
    FUNC_REMU   = 5'h1b
  } func_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_t;

  // Destination physical register tag
  typedef logic [5:0] preg_t;

endpackage

`default_nettype wire

// ==== source/iu_top.sv ====
// Integer execution unit top: ALU, pipelined multiplier, iterative divider
// One instruction per cycle, accepted when inst_vld is high and stall is low
// ALU and multiply write back two edges after acceptance, in order
// Divide results take the port only in cycles with no pipelined result
// Flush discards all work in flight and blocks the instruction offered with it

`timescale 1ns/1ps
`default_nettype none

module iu_top #(
  parameter int XLEN = 32
) (
  input  logic            forever_cpuclk,
  input  logic            arst_n,
  input  logic            flush,
  input  logic            inst_vld,
  input  iu_pkg::func_t   func,
  input  logic [XLEN-1:0] src0,
  input  logic [XLEN-1:0] src1,
  input  iu_pkg::preg_t   dst_preg,
  output logic            stall,
  output logic            wb_vld,
  output iu_pkg::preg_t   wb_preg,
  output logic [XLEN-1:0] wb_data
);

  logic            alu_sel;
  logic            mul_sel;
  logic            div_sel;
  iu_pkg::alu_op_t alu_op;
  logic            mul_high;
  logic            mul_src0_signed;
  logic            mul_src1_signed;
  logic            div_signed;
  logic            div_rem;
  logic [XLEN-1:0] alu_rslt;
  logic [XLEN-1:0] mul_rslt;
  logic            div_done;
  logic            div_grant;
  logic [XLEN-1:0] div_rslt;
  iu_pkg::preg_t   div_preg;

  iu_decode i_decode (
    .inst_vld        (inst_vld),
    .func            (func),
    .alu_sel         (alu_sel),
    .mul_sel         (mul_sel),
    .div_sel         (div_sel),
    .alu_op          (alu_op),
    .mul_high        (mul_high),
    .mul_src0_signed (mul_src0_signed),
    .mul_src1_signed (mul_src1_signed),
    .div_signed      (div_signed),
    .div_rem         (div_rem)
  );

  iu_alu #(.XLEN(XLEN)) i_alu (
    .alu_op (alu_op),
    .src0   (src0),
    .src1   (src1),
    .rslt   (alu_rslt)
  );

  iu_mul #(.XLEN(XLEN)) i_mul (
    .forever_cpuclk  (forever_cpuclk),
    .arst_n          (arst_n),
    .flush           (flush),
    .mul_sel         (mul_sel),
    .mul_high        (mul_high),
    .mul_src0_signed (mul_src0_signed),
    .mul_src1_signed (mul_src1_signed),
    .src0            (src0),
    .src1            (src1),
    .rslt            (mul_rslt)
  );

  // Owns the only issue stall
  iu_div #(.XLEN(XLEN)) i_div (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .flush          (flush),
    .div_sel        (div_sel),
    .div_signed     (div_signed),
    .div_rem        (div_rem),
    .src0           (src0),
    .src1           (src1),
    .dst_preg       (dst_preg),
    .div_grant      (div_grant),
    .stall          (stall),
    .done           (div_done),
    .rslt           (div_rslt),
    .preg           (div_preg)
  );

  iu_wb_ctrl #(.XLEN(XLEN)) i_wb_ctrl (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .flush          (flush),
    .alu_sel        (alu_sel),
    .mul_sel        (mul_sel),
    .dst_preg       (dst_preg),
    .alu_rslt       (alu_rslt),
    .mul_rslt       (mul_rslt),
    .div_done       (div_done),
    .div_rslt       (div_rslt),
    .div_preg       (div_preg),
    .div_grant      (div_grant),
    .wb_vld         (wb_vld),
    .wb_preg        (wb_preg),
    .wb_data        (wb_data)
  );

endmodule

`default_nettype wire

// ==== source/iu_wb_ctrl.sv ====
// Result pipeline and write-back port arbitration
// ALU and multiply results always win; the divider is granted when stage one
// is empty. No back-pressure from the write-back side

`timescale 1ns/1ps
`default_nettype none

module iu_wb_ctrl #(
  parameter int XLEN = 32
) (
  input  logic            forever_cpuclk,
  input  logic            arst_n,
  input  logic            flush,
  input  logic            alu_sel,
  input  logic            mul_sel,
  input  iu_pkg::preg_t   dst_preg,
  input  logic [XLEN-1:0] alu_rslt,
  input  logic [XLEN-1:0] mul_rslt,
  input  logic            div_done,
  input  logic [XLEN-1:0] div_rslt,
  input  iu_pkg::preg_t   div_preg,
  output logic            div_grant,
  output logic            wb_vld,
  output iu_pkg::preg_t   wb_preg,
  output logic [XLEN-1:0] wb_data
);

  logic            s1_vld;
  logic            s1_mul;
  iu_pkg::preg_t   s1_preg;
  logic [XLEN-1:0] s1_data;

  assign div_grant = ~s1_vld;

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      s1_vld <= 1'b0;
      wb_vld <= 1'b0;
    end else if (flush) begin
      s1_vld <= 1'b0;
      wb_vld <= 1'b0;
    end else begin
      s1_vld <= alu_sel | mul_sel;
      wb_vld <= s1_vld | div_done;
    end
  end

  // Stage one payload
  always_ff @(posedge forever_cpuclk) begin
    if (alu_sel | mul_sel) begin
      s1_mul  <= mul_sel;
      s1_preg <= dst_preg;
      s1_data <= alu_rslt;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (s1_vld) begin
      wb_preg <= s1_preg;
      wb_data <= s1_mul ? mul_rslt : s1_data;
    end else if (div_done) begin
      wb_preg <= div_preg;
      wb_data <= div_rslt;
    end
  end

endmodule

`default_nettype wire
